//--- bench/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen(
	output logic clk,
	output logic arst_n
);

localparam int HALF_PERIOD  = 50;
localparam int RESET_CYCLES = 8;

initial begin
	clk = 1'b0;
	forever #HALF_PERIOD clk = ~clk;
end

// Release on a falling edge, away from the capture edge
initial begin
	arst_n = 1'b0;
	repeat (RESET_CYCLES) @(posedge clk);
	@(negedge clk);
	arst_n = 1'b1;
end

endmodule

`default_nettype wire

//--- bench/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;

localparam int N_DIRECTED = 11;
localparam int N_RAND = 24;
localparam int WATCHDOG_CYCLES = 8 + 2 * (N_DIRECTED + N_RAND) + 20;
localparam isa_pkg::Inst_t NOP = '0;

logic clk;
logic arst_n;
logic inst_valid;
isa_pkg::Inst_t inst1;
isa_pkg::Inst_t inst2;
logic inst2_taken;
pipe_pkg::RegWriteReq_t wr_a;
pipe_pkg::RegWriteReq_t wr_b;

string t_name [N_DIRECTED];
isa_pkg::Inst_t t_inst1 [N_DIRECTED];
isa_pkg::Inst_t t_inst2 [N_DIRECTED];
logic t_taken [N_DIRECTED];

pipe_pkg::Word_t model_regs [32];
pipe_pkg::RegWriteReq_t exp_a [$];
pipe_pkg::RegWriteReq_t exp_b [$];
string exp_name [$];
logic [31:0] lfsr_state;
int n_mismatch;
int n_presence;

clock_gen clk_src(.clk, .arst_n);

dual_issue_core i_dual_issue_core(
	.clk,
	.arst_n,
	.inst_valid,
	.inst1,
	.inst2,
	.inst2_taken,
	.wr_a,
	.wr_b
);

function automatic isa_pkg::Inst_t rtype(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
	return {isa_pkg::OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic isa_pkg::Inst_t itype(input logic [5:0] opc, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
	return {opc, rs, rt, imm};
endfunction

// x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] lfsr_bits(input int n);
	logic [31:0] bits;
	logic fb;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		bits = {bits[30:0], fb};
	end
	return bits;
endfunction

function automatic isa_pkg::Inst_t random_inst();
	logic [3:0] kind;
	logic [4:0] rd;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [15:0] imm;
	kind = 4'(lfsr_bits(4) % 12);
	rd = 5'(lfsr_bits(3) % 7 + 1);
	rs = 5'(lfsr_bits(3) % 7 + 1);
	rt = 5'(lfsr_bits(3) % 7 + 1);
	imm = 16'(lfsr_bits(16));
	case (kind)
		0: return rtype(isa_pkg::FN_ADDU, rd, rs, rt);
		1: return rtype(isa_pkg::FN_SUBU, rd, rs, rt);
		2: return rtype(isa_pkg::FN_AND, rd, rs, rt);
		3: return rtype(isa_pkg::FN_OR, rd, rs, rt);
		4: return rtype(isa_pkg::FN_XOR, rd, rs, rt);
		5: return rtype(isa_pkg::FN_NOR, rd, rs, rt);
		6: return rtype(isa_pkg::FN_SLT, rd, rs, rt);
		7: return itype(isa_pkg::OPC_ADDIU, rt, rs, imm);
		8: return itype(isa_pkg::OPC_ORI, rt, rs, imm);
		9: return itype(isa_pkg::OPC_ANDI, rt, rs, imm);
		10: return itype(isa_pkg::OPC_XORI, rt, rs, imm);
		default: return itype(isa_pkg::OPC_LUI, rt, 5'd0, imm);
	endcase
endfunction

function automatic logic is_supported(input isa_pkg::Inst_t inst);
	if (inst[31:26] == isa_pkg::OPC_SPECIAL)
		return inst[5:0] inside {isa_pkg::FN_ADDU, isa_pkg::FN_SUBU, isa_pkg::FN_AND,
			isa_pkg::FN_OR, isa_pkg::FN_XOR, isa_pkg::FN_NOR, isa_pkg::FN_SLT};
	return inst[31:26] inside {isa_pkg::OPC_ADDIU, isa_pkg::OPC_ORI, isa_pkg::OPC_ANDI,
		isa_pkg::OPC_XORI, isa_pkg::OPC_LUI};
endfunction

// Zero means the instruction leaves the register file alone
function automatic logic [4:0] dest_of(input isa_pkg::Inst_t inst);
	if (!is_supported(inst))
		return 5'd0;
	return (inst[31:26] == isa_pkg::OPC_SPECIAL) ? inst[15:11] : inst[20:16];
endfunction

function automatic logic lane_b_waits(input isa_pkg::Inst_t i1, input isa_pkg::Inst_t i2);
	logic [4:0] dst;
	logic reads_rs;
	logic reads_rt;
	dst = dest_of(i1);
	reads_rs = is_supported(i2) && i2[31:26] != isa_pkg::OPC_LUI;
	reads_rt = is_supported(i2) && i2[31:26] == isa_pkg::OPC_SPECIAL;
	return dst != 0 && ((reads_rs && i2[25:21] == dst) || (reads_rt && i2[20:16] == dst));
endfunction

function automatic pipe_pkg::Word_t isa_result(input isa_pkg::Inst_t inst);
	pipe_pkg::Word_t a;
	pipe_pkg::Word_t b;
	logic [15:0] imm;
	a = model_regs[inst[25:21]];
	b = model_regs[inst[20:16]];
	imm = inst[15:0];
	if (inst[31:26] == isa_pkg::OPC_SPECIAL) begin
		case (inst[5:0])
			isa_pkg::FN_ADDU: return a + b;
			isa_pkg::FN_SUBU: return a - b;
			isa_pkg::FN_AND: return a & b;
			isa_pkg::FN_OR: return a | b;
			isa_pkg::FN_XOR: return a ^ b;
			isa_pkg::FN_NOR: return ~(a | b);
			default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		endcase
	end
	case (inst[31:26])
		isa_pkg::OPC_ADDIU: return a + {{16{imm[15]}}, imm};
		isa_pkg::OPC_ORI: return a | {16'h0, imm};
		isa_pkg::OPC_ANDI: return a & {16'h0, imm};
		isa_pkg::OPC_XORI: return a ^ {16'h0, imm};
		default: return {imm, 16'h0};
	endcase
endfunction

task automatic run_model(input isa_pkg::Inst_t inst, output pipe_pkg::RegWriteReq_t req);
	req = '0;
	if (dest_of(inst) != 0) begin
		req.we = 1'b1;
		req.waddr = dest_of(inst);
		req.wdata = isa_result(inst);
		model_regs[req.waddr] = req.wdata;
	end
endtask

task automatic check_lane(input string name, input string lane,
		input pipe_pkg::RegWriteReq_t exp, input pipe_pkg::RegWriteReq_t act);
	assert (exp.we == act.we) else begin
		n_presence++;
		if (exp.we)
			$display("%s lane %s: expected write to r%0d did not appear", name, lane, exp.waddr);
		else
			$display("%s lane %s: unexpected write to r%0d", name, lane, act.waddr);
	end
	if (exp.we && act.we) begin
		assert (exp.waddr == act.waddr && exp.wdata == act.wdata) else begin
			n_mismatch++;
			$display("mismatch %s lane %s: expected r%0d=%h actual r%0d=%h",
				name, lane, exp.waddr, exp.wdata, act.waddr, act.wdata);
		end
	end
endtask

// The oldest entry left the EX/WB register before this falling edge
task automatic compare_outputs();
	string name;
	name = exp_name.pop_front();
	check_lane(name, "a", exp_a.pop_front(), wr_a);
	check_lane(name, "b", exp_b.pop_front(), wr_b);
endtask

task automatic present_pair(input string name, input isa_pkg::Inst_t i1,
		input isa_pkg::Inst_t i2, input logic exp_taken, output logic taken);
	pipe_pkg::RegWriteReq_t req_a;
	pipe_pkg::RegWriteReq_t req_b;
	@(negedge clk);
	compare_outputs();
	inst_valid = 1'b1;
	inst1 = i1;
	inst2 = i2;
	#10;
	assert (inst2_taken === exp_taken) else begin
		n_mismatch++;
		$display("mismatch %s inst2_taken: expected %0b actual %0b",
			name, exp_taken, inst2_taken);
	end
	run_model(i1, req_a);
	req_b = '0;
	if (exp_taken)
		run_model(i2, req_b);
	exp_a.push_back(req_a);
	exp_b.push_back(req_b);
	exp_name.push_back(name);
	taken = exp_taken;
endtask

task automatic idle_cycle();
	@(negedge clk);
	compare_outputs();
	inst_valid = 1'b0;
	exp_a.push_back('0);
	exp_b.push_back('0);
	exp_name.push_back("idle");
endtask

task automatic add_entry(input int i, input string name, input isa_pkg::Inst_t i1,
		input isa_pkg::Inst_t i2, input logic taken);
	t_name[i] = name;
	t_inst1[i] = i1;
	t_inst2[i] = i2;
	t_taken[i] = taken;
endtask

task automatic build_table();
	add_entry(0, "lui_ori", itype(isa_pkg::OPC_LUI, 1, 0, 16'h8000),
		itype(isa_pkg::OPC_ORI, 2, 0, 16'h1234), 1'b1);
	add_entry(1, "addiu_neg", itype(isa_pkg::OPC_ADDIU, 3, 0, 16'hfffb),
		itype(isa_pkg::OPC_XORI, 4, 2, 16'hffff), 1'b1);
	add_entry(2, "slt_neg", rtype(isa_pkg::FN_SLT, 5, 3, 2), rtype(isa_pkg::FN_SLT, 6, 2, 3), 1'b1);
	add_entry(3, "dep_pair", rtype(isa_pkg::FN_ADDU, 7, 1, 3),
		rtype(isa_pkg::FN_SUBU, 8, 7, 5), 1'b0);
	add_entry(4, "andi_nor", itype(isa_pkg::OPC_ANDI, 9, 4, 16'h0f0f),
		rtype(isa_pkg::FN_NOR, 10, 1, 2), 1'b1);
	add_entry(5, "r0_write", itype(isa_pkg::OPC_ADDIU, 0, 0, 16'h0055),
		rtype(isa_pkg::FN_OR, 11, 0, 0), 1'b1);
	add_entry(6, "bad_enc", 32'hfc00_0000, rtype(isa_pkg::FN_ADDU, 12, 0, 2), 1'b1);
	add_entry(7, "same_dst", itype(isa_pkg::OPC_ADDIU, 13, 0, 16'h0001),
		itype(isa_pkg::OPC_ADDIU, 13, 0, 16'h0002), 1'b1);
	add_entry(8, "read_same", rtype(isa_pkg::FN_XOR, 14, 13, 0),
		itype(isa_pkg::OPC_ANDI, 15, 14, 16'h00ff), 1'b0);
	add_entry(9, "file_read", rtype(isa_pkg::FN_OR, 16, 8, 13),
		rtype(isa_pkg::FN_ADDU, 17, 1, 5), 1'b1);
	// ADD and SLTU trap or compare unsigned and sit outside the subset
	add_entry(10, "bad_funct", rtype(6'h20, 18, 1, 2), rtype(6'h2b, 19, 1, 2), 1'b1);
endtask

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk);
	$display("timeout: the test sequence did not finish in time");
	$display("Simulation failed");
	$finish;
end

initial begin
	logic taken;
	isa_pkg::Inst_t ri1;
	isa_pkg::Inst_t ri2;
	inst_valid = 1'b0;
	inst1 = NOP;
	inst2 = NOP;
	lfsr_state = 32'h785a;
	n_mismatch = 0;
	n_presence = 0;
	for (int r = 0; r < 32; r++)
		model_regs[r] = '0;
	build_table();
	// The two stages are empty coming out of reset
	repeat (2) begin
		exp_a.push_back('0);
		exp_b.push_back('0);
		exp_name.push_back("reset");
	end
	@(posedge arst_n);
	for (int i = 0; i < N_DIRECTED; i++) begin
		present_pair(t_name[i], t_inst1[i], t_inst2[i], t_taken[i], taken);
		if (!taken)
			present_pair({t_name[i], "_held"}, t_inst2[i], NOP, 1'b1, taken);
	end
	for (int i = 0; i < N_RAND; i++) begin
		ri1 = random_inst();
		ri2 = random_inst();
		present_pair($sformatf("rand_%0d", i), ri1, ri2, !lane_b_waits(ri1, ri2), taken);
		if (!taken)
			present_pair($sformatf("rand_%0d_held", i), ri2, NOP, 1'b1, taken);
	end
	repeat (2) idle_cycle();
	$display("errors: %0d value mismatches, %0d missing or unexpected writes",
		n_mismatch, n_presence);
	if (n_mismatch + n_presence == 0)
		$display("Simulation completed successfully");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

`default_nettype wire

//--- dual_issue_core.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/cpu_id.sv
rtl/issue_ctrl.sv
rtl/cpu_ex.sv
rtl/reg_file.sv
rtl/dual_issue_core.sv
bench/clock_gen.sv
bench/core_tb.sv

//--- rtl/cpu_ex.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_ex(
	input  logic                   clk,
	input  logic                   arst_n,
	input  pipe_pkg::DecodedInst_t dec,
	input  logic                   issue,
	output pipe_pkg::RegWriteReq_t ex_wr
);

logic idex_valid;
logic idex_we;
isa_pkg::AluOp_t idex_op;
pipe_pkg::Word_t idex_opa;
pipe_pkg::Word_t idex_opb;
pipe_pkg::RegAddr_t idex_waddr;
pipe_pkg::Word_t result;

// ID/EX control
always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		idex_valid <= 1'b0;
		idex_we    <= 1'b0;
	end else begin
		idex_valid <= dec.valid && issue;
		idex_we    <= dec.we && issue;
	end
end

// ID/EX payload
always_ff @(posedge clk) begin
	idex_op    <= dec.op;
	idex_opa   <= dec.opa;
	idex_opb   <= dec.opb;
	idex_waddr <= dec.waddr;
end

always_comb begin
	case (idex_op)
		isa_pkg::ALU_ADD: result = idex_opa + idex_opb;
		isa_pkg::ALU_SUB: result = idex_opa - idex_opb;
		isa_pkg::ALU_AND: result = idex_opa & idex_opb;
		isa_pkg::ALU_OR:  result = idex_opa | idex_opb;
		isa_pkg::ALU_XOR: result = idex_opa ^ idex_opb;
		isa_pkg::ALU_NOR: result = ~(idex_opa | idex_opb);
		isa_pkg::ALU_SLT: result = {31'b0, $signed(idex_opa) < $signed(idex_opb)};
		isa_pkg::ALU_LUI: result = {idex_opb[isa_pkg::IMM_W-1:0], {isa_pkg::IMM_W{1'b0}}};
		default:          result = '0;
	endcase
end

// Writes to r0 are dropped here, not downstream
assign ex_wr.we    = idex_valid && idex_we && idex_waddr != '0;
assign ex_wr.waddr = idex_waddr;
assign ex_wr.wdata = result;

a_invalid_entry_no_we: assert property (
	@(posedge clk) disable iff (!arst_n)
	!idex_valid |-> !idex_we
) else $error("write enable set on an invalid ID/EX entry");

endmodule

`default_nettype wire

//--- rtl/cpu_id.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_id(
	input  isa_pkg::Inst_t                              inst,
	input  logic                                        valid,
	input  pipe_pkg::RegWriteReq_t [pipe_pkg::LANES-1:0] ex_wr,
	input  pipe_pkg::RegWriteReq_t [pipe_pkg::LANES-1:0] wb_wr,
	input  pipe_pkg::Word_t                             rdata1,
	input  pipe_pkg::Word_t                             rdata2,
	output pipe_pkg::RegAddr_t                          raddr1,
	output pipe_pkg::RegAddr_t                          raddr2,
	output pipe_pkg::DecodedInst_t                      dec,
	output logic                                        rs_used,
	output logic                                        rt_used
);

logic [5:0] opcode;
logic [5:0] funct;
pipe_pkg::RegAddr_t rs;
pipe_pkg::RegAddr_t rt;
pipe_pkg::RegAddr_t rd;
logic [isa_pkg::IMM_W-1:0] imm;
pipe_pkg::Word_t imm_ext;
isa_pkg::AluOp_t op;
logic is_imm;

assign opcode = inst[isa_pkg::OPC_LSB +: 6];
assign funct  = inst[isa_pkg::FN_LSB +: 6];
assign rs     = inst[isa_pkg::RS_LSB +: 5];
assign rt     = inst[isa_pkg::RT_LSB +: 5];
assign rd     = inst[isa_pkg::RD_LSB +: 5];
assign imm    = inst[isa_pkg::IMM_LSB +: isa_pkg::IMM_W];

assign raddr1 = rs;
assign raddr2 = rt;

// Newest write wins, lane b over lane a within a stage
function automatic pipe_pkg::Word_t pick_source(
	input pipe_pkg::RegAddr_t                          addr,
	input pipe_pkg::Word_t                             file_data,
	input pipe_pkg::RegWriteReq_t [pipe_pkg::LANES-1:0] ex,
	input pipe_pkg::RegWriteReq_t [pipe_pkg::LANES-1:0] wb
);
	pipe_pkg::Word_t data;
	data = file_data;
	for (int i = 0; i < pipe_pkg::LANES; i++) begin
		if (wb[i].we && wb[i].waddr == addr)
			data = wb[i].wdata;
	end
	for (int i = 0; i < pipe_pkg::LANES; i++) begin
		if (ex[i].we && ex[i].waddr == addr)
			data = ex[i].wdata;
	end
	if (addr == '0)
		data = '0;
	return data;
endfunction

always_comb begin
	op     = isa_pkg::ALU_NONE;
	is_imm = 1'b1;
	case (opcode)
		isa_pkg::OPC_SPECIAL: begin
			is_imm = 1'b0;
			case (funct)
				isa_pkg::FN_ADDU: op = isa_pkg::ALU_ADD;
				isa_pkg::FN_SUBU: op = isa_pkg::ALU_SUB;
				isa_pkg::FN_AND:  op = isa_pkg::ALU_AND;
				isa_pkg::FN_OR:   op = isa_pkg::ALU_OR;
				isa_pkg::FN_XOR:  op = isa_pkg::ALU_XOR;
				isa_pkg::FN_NOR:  op = isa_pkg::ALU_NOR;
				isa_pkg::FN_SLT:  op = isa_pkg::ALU_SLT;
				default:          op = isa_pkg::ALU_NONE;
			endcase
		end
		isa_pkg::OPC_ADDIU: op = isa_pkg::ALU_ADD;
		isa_pkg::OPC_ANDI:  op = isa_pkg::ALU_AND;
		isa_pkg::OPC_ORI:   op = isa_pkg::ALU_OR;
		isa_pkg::OPC_XORI:  op = isa_pkg::ALU_XOR;
		isa_pkg::OPC_LUI:   op = isa_pkg::ALU_LUI;
		default:            op = isa_pkg::ALU_NONE;
	endcase
end

// LUI has no register source, immediates have no rt source
assign rs_used = op != isa_pkg::ALU_NONE && op != isa_pkg::ALU_LUI;
assign rt_used = op != isa_pkg::ALU_NONE && !is_imm;

// Only ADDIU sign-extends
assign imm_ext = (opcode == isa_pkg::OPC_ADDIU)
	? {{(32 - isa_pkg::IMM_W){imm[isa_pkg::IMM_W-1]}}, imm}
	: {{(32 - isa_pkg::IMM_W){1'b0}}, imm};

always_comb begin
	dec.valid = valid;
	dec.op    = op;
	dec.opa   = pick_source(rs, rdata1, ex_wr, wb_wr);
	dec.opb   = is_imm ? imm_ext : pick_source(rt, rdata2, ex_wr, wb_wr);
	dec.waddr = is_imm ? rt : rd;
	dec.we    = valid && op != isa_pkg::ALU_NONE;
end

endmodule

`default_nettype wire

//--- rtl/dual_issue_core.sv
`timescale 1ns/1ns
`default_nettype none

module dual_issue_core(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   inst_valid,
	input  isa_pkg::Inst_t         inst1,
	input  isa_pkg::Inst_t         inst2,
	output logic                   inst2_taken,
	output pipe_pkg::RegWriteReq_t wr_a,
	output pipe_pkg::RegWriteReq_t wr_b
);

pipe_pkg::DecodedInst_t dec_a;
pipe_pkg::DecodedInst_t dec_b;
pipe_pkg::RegAddr_t raddr_a1;
pipe_pkg::RegAddr_t raddr_a2;
pipe_pkg::RegAddr_t raddr_b1;
pipe_pkg::RegAddr_t raddr_b2;
pipe_pkg::Word_t [pipe_pkg::READ_PORTS-1:0] rdata;
logic rs_used_b;
logic rt_used_b;
pipe_pkg::RegWriteReq_t ex_wr_a;
pipe_pkg::RegWriteReq_t ex_wr_b;

// Decode, lane a reads ports 0-1 and lane b ports 2-3
cpu_id stage_id_a(
	.inst(inst1),
	.valid(inst_valid),
	.ex_wr({ex_wr_b, ex_wr_a}),
	.wb_wr({wr_b, wr_a}),
	.rdata1(rdata[0]),
	.rdata2(rdata[1]),
	.raddr1(raddr_a1),
	.raddr2(raddr_a2),
	.dec(dec_a),
	.rs_used(),
	.rt_used()
);

cpu_id stage_id_b(
	.inst(inst2),
	.valid(inst_valid),
	.ex_wr({ex_wr_b, ex_wr_a}),
	.wb_wr({wr_b, wr_a}),
	.rdata1(rdata[2]),
	.rdata2(rdata[3]),
	.raddr1(raddr_b1),
	.raddr2(raddr_b2),
	.dec(dec_b),
	.rs_used(rs_used_b),
	.rt_used(rt_used_b)
);

issue_ctrl issue_ctrl_instance(
	.dec_a,
	.dec_b,
	.rs_addr_b(raddr_b1),
	.rt_addr_b(raddr_b2),
	.rs_used_b,
	.rt_used_b,
	.inst2_taken
);

// Execute
cpu_ex stage_ex_a(
	.clk,
	.arst_n,
	.dec(dec_a),
	.issue(inst_valid),
	.ex_wr(ex_wr_a)
);

cpu_ex stage_ex_b(
	.clk,
	.arst_n,
	.dec(dec_b),
	.issue(inst_valid && inst2_taken),
	.ex_wr(ex_wr_b)
);

// Result stage and register file
reg_file reg_file_instance(
	.clk,
	.arst_n,
	.ex_wr_a,
	.ex_wr_b,
	.raddr({raddr_b2, raddr_b1, raddr_a2, raddr_a1}),
	.rdata,
	.wr_a,
	.wr_b
);

endmodule

`default_nettype wire

//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [31:0] Inst_t;

	// Instruction field positions
	localparam int OPC_LSB = 26;
	localparam int RS_LSB  = 21;
	localparam int RT_LSB  = 16;
	localparam int RD_LSB  = 11;
	localparam int FN_LSB  = 0;
	localparam int IMM_LSB = 0;
	localparam int IMM_W   = 16;

	// Major opcodes
	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_ADDIU   = 6'h09;
	localparam logic [5:0] OPC_ANDI    = 6'h0c;
	localparam logic [5:0] OPC_ORI     = 6'h0d;
	localparam logic [5:0] OPC_XORI    = 6'h0e;
	localparam logic [5:0] OPC_LUI     = 6'h0f;

	// SPECIAL function codes
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_LUI,
		ALU_NONE
	} AluOp_t;

endpackage

`default_nettype wire

//--- rtl/issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl(
	input  pipe_pkg::DecodedInst_t dec_a,
	input  pipe_pkg::DecodedInst_t dec_b,
	input  pipe_pkg::RegAddr_t     rs_addr_b,
	input  pipe_pkg::RegAddr_t     rt_addr_b,
	input  logic                   rs_used_b,
	input  logic                   rt_used_b,
	output logic                   inst2_taken
);

logic a_writes;
logic rs_hit;
logic rt_hit;

// Register zero never creates a dependence
assign a_writes = dec_a.we && dec_a.waddr != '0;

assign rs_hit = rs_used_b && rs_addr_b == dec_a.waddr;
assign rt_hit = rt_used_b && rt_addr_b == dec_a.waddr;

// Write-write on the same register still pairs
assign inst2_taken = !(dec_b.valid && a_writes && (rs_hit || rt_hit));

always_comb begin
	a_hold_needs_valid: assert final (inst2_taken || dec_a.valid)
		else $error("lane b held back by an invalid lane a");
end

endmodule

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	localparam int LANES      = 2;
	localparam int READ_PORTS = 4;
	localparam int REG_COUNT  = 32;

	typedef logic [31:0] Word_t;
	typedef logic [4:0]  RegAddr_t;

	typedef struct packed {
		logic     we;
		RegAddr_t waddr;
		Word_t    wdata;
	} RegWriteReq_t;

	// Operands are already resolved when this leaves decode
	typedef struct packed {
		logic            valid;
		isa_pkg::AluOp_t op;
		Word_t           opa;
		Word_t           opb;
		RegAddr_t        waddr;
		logic            we;
	} DecodedInst_t;

endpackage

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file(
	input  logic                                            clk,
	input  logic                                            arst_n,
	input  pipe_pkg::RegWriteReq_t                          ex_wr_a,
	input  pipe_pkg::RegWriteReq_t                          ex_wr_b,
	input  pipe_pkg::RegAddr_t [pipe_pkg::READ_PORTS-1:0]   raddr,
	output pipe_pkg::Word_t [pipe_pkg::READ_PORTS-1:0]      rdata,
	output pipe_pkg::RegWriteReq_t                          wr_a,
	output pipe_pkg::RegWriteReq_t                          wr_b
);

// EX/WB stage, index 0 is lane a
logic [pipe_pkg::LANES-1:0] wb_we;
pipe_pkg::RegAddr_t [pipe_pkg::LANES-1:0] wb_waddr;
pipe_pkg::Word_t [pipe_pkg::LANES-1:0] wb_wdata;

pipe_pkg::Word_t regs [pipe_pkg::REG_COUNT];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		wb_we <= '0;
		for (int i = 0; i < pipe_pkg::REG_COUNT; i++)
			regs[i] <= '0;
	end else begin
		wb_we <= {ex_wr_b.we, ex_wr_a.we};
		// Lane b is applied last and wins on a shared destination
		for (int l = 0; l < pipe_pkg::LANES; l++) begin
			if (wb_we[l])
				regs[wb_waddr[l]] <= wb_wdata[l];
		end
	end
end

always_ff @(posedge clk) begin
	wb_waddr <= {ex_wr_b.waddr, ex_wr_a.waddr};
	wb_wdata <= {ex_wr_b.wdata, ex_wr_a.wdata};
end

assign wr_a = '{we: wb_we[0], waddr: wb_waddr[0], wdata: wb_wdata[0]};
assign wr_b = '{we: wb_we[1], waddr: wb_waddr[1], wdata: wb_wdata[1]};

// Write-through for the value landing at the next edge
always_comb begin
	for (int p = 0; p < pipe_pkg::READ_PORTS; p++) begin
		rdata[p] = regs[raddr[p]];
		for (int l = 0; l < pipe_pkg::LANES; l++) begin
			if (wb_we[l] && wb_waddr[l] == raddr[p])
				rdata[p] = wb_wdata[l];
		end
		if (raddr[p] == '0)
			rdata[p] = '0;
	end
end

a_no_r0_write: assert property (
	@(posedge clk) disable iff (!arst_n)
	!(wb_we[0] && wb_waddr[0] == '0) && !(wb_we[1] && wb_waddr[1] == '0)
) else $error("write to register zero reached the file");

endmodule

`default_nettype wire
